/* src/cpuPkg.sv */
package cpuPkg;

	localparam int dataWidth = 32;  // default bus width
	localparam int numRegs = 16;    // default general register count
	localparam int ctrlWidth = 32;  // width of the enable and busSelect words

	// bus source positions in busSelect, 0..15 are r0..r15
	localparam int srcHi = 16;
	localparam int srcLo = 17;
	localparam int srcZHi = 18;
	localparam int srcZLo = 19;
	localparam int srcPc = 20;
	localparam int srcMdr = 21;
	localparam int srcInPort = 22;

	// load enable positions in enable, 0..15 are r0..r15
	localparam int enHi = 16;
	localparam int enLo = 17;
	localparam int enZIn = 18;      // Z pair takes the ALU result
	localparam int enY = 19;
	localparam int enPc = 20;
	localparam int enIncPc = 21;    // wins over enPc
	localparam int enIr = 22;
	localparam int enMar = 23;
	localparam int enMdr = 24;
	localparam int enOutPort = 25;

	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOr  = 4'd3,
		opShl = 4'd4,
		opShr = 4'd5,
		opRol = 4'd6,
		opRor = 4'd7,
		opNeg = 4'd8,
		opNot = 4'd9,
		opMul = 4'd10,
		opDiv = 4'd11
	} aluOp_e;

endpackage

/* src/busMux.sv */
`timescale 1ns/1ps

// shared bus driver
// every selected source is ORed in, so an idle select gives a zero bus
module busMux import cpuPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic [ctrlWidth-1:0] busSelect,
	input  logic [width-1:0]     regs [numRegs],
	input  logic [width-1:0]     hi,
	input  logic [width-1:0]     lo,
	input  logic [width-1:0]     zHi,
	input  logic [width-1:0]     zLo,
	input  logic [width-1:0]     pc,
	input  logic [width-1:0]     mdr,
	input  logic [width-1:0]     inPort,
	output logic [width-1:0]     busOut
);

	always_comb begin
		busOut = '0;

		// general registers sit at the low select bits
		for (int i = 0; i < numRegs; i++) begin
			if (busSelect[i])
				busOut = busOut | regs[i];
		end

		if (busSelect[srcHi])
			busOut = busOut | hi;
		if (busSelect[srcLo])
			busOut = busOut | lo;
		if (busSelect[srcZHi])
			busOut = busOut | zHi;
		if (busSelect[srcZLo])
			busOut = busOut | zLo;
		if (busSelect[srcPc])
			busOut = busOut | pc;     // old PC during an increment
		if (busSelect[srcMdr])
			busOut = busOut | mdr;
		if (busSelect[srcInPort])
			busOut = busOut | inPort; // straight from the pins
	end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps

// general purpose registers r0..r(nRegs-1)
// r0 is an ordinary register, no hardwired zero
module regFile import cpuPkg::*; #(
	parameter int width = dataWidth,
	parameter int nRegs = numRegs
) (
	input  logic              clk,
	input  logic              rstN,
	input  logic [nRegs-1:0]  regEnable, // one load bit per register
	input  logic [width-1:0]  busIn,
	output logic [width-1:0]  regs [nRegs]
);

	logic [width-1:0] regQ [nRegs];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < nRegs; i++) begin
				regQ[i] <= '0;
			end
		end else begin
			for (int i = 0; i < nRegs; i++) begin
				if (regEnable[i])
					regQ[i] <= busIn;  // several may load the same value
			end
		end
	end

	// drive the output array from the storage
	always_comb begin
		for (int i = 0; i < nRegs; i++) begin
			regs[i] = regQ[i];
		end
	end

endmodule

/* src/memInterface.sv */
`timescale 1ns/1ps

// memory side registers
// MAR goes off-chip, MDR takes memory data or the bus
module memInterface import cpuPkg::*; #(
	parameter int width = dataWidth
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             marEn,
	input  logic             mdrEn,
	input  logic             mdRead,   // high selects memory data
	input  logic [width-1:0] busIn,
	input  logic [width-1:0] mDataIn,
	output logic [width-1:0] mar,
	output logic [width-1:0] mdr
);

	logic [width-1:0] mdrNext;

	assign mdrNext = mdRead ? mDataIn : busIn;  // MDR input mux

	always_ff @(posedge clk) begin
		if (!rstN) begin
			mar <= '0;
			mdr <= '0;
		end else begin
			if (marEn)
				mar <= busIn;
			if (mdrEn)
				mdr <= mdrNext;
		end
	end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

// combinational ALU
// a is the latched Y operand, b comes from the bus
// result is double width so a product or quotient/remainder fits in Z
module alu import cpuPkg::*; #(
	parameter int width = dataWidth
) (
	input  aluOp_e             aluOp,
	input  logic [width-1:0]   a,
	input  logic [width-1:0]   b,
	output logic [2*width-1:0] result
);

	localparam int shW = $clog2(width);  // five bits at 32

	logic [shW-1:0]           shAmt;
	logic [2*width-1:0]       rotL;
	logic [2*width-1:0]       rotR;
	logic signed [2*width-1:0] product;
	logic [width-1:0]         quotient;
	logic [width-1:0]         remainder;
	logic [width-1:0]         word;     // single word result

	assign shAmt = b[shW-1:0];

	// rotate through a doubled copy of a
	assign rotL = {a, a} << shAmt;
	assign rotR = {a, a} >> shAmt;

	// signed full product, both operands sign extended by context
	assign product = $signed(a) * $signed(b);

	always_comb begin
		if (b == '0) begin
			quotient = '1;       // divide by zero
			remainder = a;
		end else begin
			quotient = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b);
		end
	end

	always_comb begin
		word = '0;
		case (aluOp)
			opAdd: word = a + b;
			opSub: word = a - b;
			opAnd: word = a & b;
			opOr:  word = a | b;
			opShl: word = a << shAmt;
			opShr: word = a >> shAmt;       // logical
			opRol: word = rotL[2*width-1:width];
			opRor: word = rotR[width-1:0];
			opNeg: word = '0 - b;           // unary ops act on the bus
			opNot: word = ~b;
			default: word = '0;
		endcase
	end

	always_comb begin
		case (aluOp)
			opMul:
				result = product;
			opDiv:
				result = {remainder, quotient}; // zHi gets remainder
			default:
				result = {{width{1'b0}}, word};
		endcase
	end

endmodule

/* src/datapath.sv */
`timescale 1ns/1ps

// single bus datapath
// one transfer per clock, every register loads from busOut on its enable
module datapath import cpuPkg::*; #(
	parameter int width = dataWidth,
	parameter int nRegs = numRegs
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic [ctrlWidth-1:0] enable,
	input  logic [ctrlWidth-1:0] busSelect,
	input  logic [width-1:0]     mDataIn,
	input  logic                 mdRead,
	input  logic [width-1:0]     inPort,
	input  aluOp_e               aluOp,
	output logic [width-1:0]     busOut,
	output logic [width-1:0]     mar,
	output logic [width-1:0]     pc,
	output logic [width-1:0]     ir,
	output logic [width-1:0]     zHi,
	output logic [width-1:0]     zLo,
	output logic [width-1:0]     hi,
	output logic [width-1:0]     lo,
	output logic [width-1:0]     outPort
);

	logic [width-1:0]   regs [nRegs];
	logic [width-1:0]   mdr;
	logic [width-1:0]   y;
	logic [2*width-1:0] aluResult;

	busMux #(
		.width(width)
	) uBusMux (
		.busSelect(busSelect),
		.regs     (regs),
		.hi       (hi),
		.lo       (lo),
		.zHi      (zHi),
		.zLo      (zLo),
		.pc       (pc),
		.mdr      (mdr),
		.inPort   (inPort),
		.busOut   (busOut)
	);

	regFile #(
		.width(width),
		.nRegs(nRegs)
	) uRegFile (
		.clk      (clk),
		.rstN     (rstN),
		.regEnable(enable[nRegs-1:0]),
		.busIn    (busOut),
		.regs     (regs)
	);

	memInterface #(
		.width(width)
	) uMemInterface (
		.clk    (clk),
		.rstN   (rstN),
		.marEn  (enable[enMar]),
		.mdrEn  (enable[enMdr]),
		.mdRead (mdRead),
		.busIn  (busOut),
		.mDataIn(mDataIn),
		.mar    (mar),
		.mdr    (mdr)
	);

	alu #(
		.width(width)
	) uAlu (
		.aluOp (aluOp),
		.a     (y),
		.b     (busOut),
		.result(aluResult)
	);

	// program counter, increment wins over a bus load
	always_ff @(posedge clk) begin
		if (!rstN)
			pc <= '0;
		else if (enable[enIncPc])
			pc <= pc + 1'b1;
		else if (enable[enPc])
			pc <= busOut;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ir <= '0;
			y <= '0;
			zHi <= '0;
			zLo <= '0;
			hi <= '0;
			lo <= '0;
			outPort <= '0;
		end else begin
			if (enable[enIr])
				ir <= busOut;          // latched only, not decoded here
			if (enable[enY])
				y <= busOut;
			if (enable[enZIn])
				{zHi, zLo} <= aluResult;
			if (enable[enHi])
				hi <= busOut;
			if (enable[enLo])
				lo <= busOut;
			if (enable[enOutPort])
				outPort <= busOut;
		end
	end

endmodule

/* tb/datapath_props.sv */
`timescale 1ns/1ps

// checks bound into every datapath instance
module datapathProps import cpuPkg::*; #(
	parameter int width = dataWidth
) (
	input logic                 clk,
	input logic                 rstN,
	input logic [ctrlWidth-1:0] enable,
	input logic [ctrlWidth-1:0] busSelect,
	input logic [width-1:0]     pc,
	input logic [width-1:0]     outPort
);

	int assertFails = 0;  // failure tally for the testbench

	// at most one source on the bus
	busOneHot: assert property (@(posedge clk) $onehot0(busSelect))
		else begin
			$error("busSelect %h drives more than one source", busSelect);
			assertFails++;
		end

	resetClears: assert property (@(posedge clk) !rstN |=> (pc == '0 && outPort == '0))
		else begin
			$error("pc or outPort not zero after reset");
			assertFails++;
		end

	pcIncrement: assert property (@(posedge clk) disable iff (!rstN)
			enable[enIncPc] |=> pc == $past(pc) + 1'b1)
		else begin
			$error("pc did not advance by one after incPc");
			assertFails++;
		end

endmodule

bind datapath datapathProps #(
	.width(width)
) uProps (
	.clk      (clk),
	.rstN     (rstN),
	.enable   (enable),
	.busSelect(busSelect),
	.pc       (pc),
	.outPort  (outPort)
);

/* tb/datapathTb.sv */
`timescale 1ns/1ps

// testbench for the single bus datapath
// each data line is one bus transfer plus the outputs expected while it is applied
module datapathTb import cpuPkg::*; ();

	localparam int clkPeriod = 10;
	localparam int resetCycles = 10;
	localparam int maxSteps = 128;
	localparam int numFields = 16;
	localparam string dataFile = "tb/datapath_testdata.txt";

	// column positions in a data line
	localparam int fEnable = 0;
	localparam int fSelect = 1;
	localparam int fMData = 2;
	localparam int fMdRead = 3;
	localparam int fInPort = 4;
	localparam int fAluOp = 5;
	localparam int fMask = 6;
	localparam int fBus = 7;   // expected outputs start here, mask bit 0

	logic        clk;
	logic        rstN;
	logic [31:0] enable;
	logic [31:0] busSelect;
	logic [31:0] mDataIn;
	logic        mdRead;
	logic [31:0] inPort;
	aluOp_e      aluOp;
	logic [31:0] busOut;
	logic [31:0] mar;
	logic [31:0] pc;
	logic [31:0] ir;
	logic [31:0] zHi;
	logic [31:0] zLo;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] outPort;

	logic [31:0] stepTable [maxSteps][numFields];
	int numSteps = 0;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	bit fileOk;

	datapath #(
		.width(32),
		.nRegs(16)
	) UUT (
		.clk      (clk),
		.rstN     (rstN),
		.enable   (enable),
		.busSelect(busSelect),
		.mDataIn  (mDataIn),
		.mdRead   (mdRead),
		.inPort   (inPort),
		.aluOp    (aluOp),
		.busOut   (busOut),
		.mar      (mar),
		.pc       (pc),
		.ir       (ir),
		.zHi      (zHi),
		.zLo      (zLo),
		.hi       (hi),
		.lo       (lo),
		.outPort  (outPort)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic loadSteps(output bit ok);
		int fd;
		int nRead;
		string line;
		ok = 1'b0;
		fd = $fopen(dataFile, "r");
		if (fd == 0)
			return;
		while (!$feof(fd) && numSteps < maxSteps) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
				continue;  // comments and blank lines
			nRead = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				stepTable[numSteps][0], stepTable[numSteps][1], stepTable[numSteps][2],
				stepTable[numSteps][3], stepTable[numSteps][4], stepTable[numSteps][5],
				stepTable[numSteps][6], stepTable[numSteps][7], stepTable[numSteps][8],
				stepTable[numSteps][9], stepTable[numSteps][10], stepTable[numSteps][11],
				stepTable[numSteps][12], stepTable[numSteps][13], stepTable[numSteps][14],
				stepTable[numSteps][15]);
			if (nRead == numFields) begin
				numSteps++;
			end else begin
				errorCount++;
				$display("test data line has %0d fields instead of %0d: %s", nRead, numFields, line);
			end
		end
		$fclose(fd);
		ok = (numSteps > 0);
	endtask

	// drive one step, picked up by the DUT at the next edge
	task automatic applyStep(input int idx);
		enable <= stepTable[idx][fEnable];
		busSelect <= stepTable[idx][fSelect];
		mDataIn <= stepTable[idx][fMData];
		mdRead <= stepTable[idx][fMdRead][0];
		inPort <= stepTable[idx][fInPort];
		aluOp <= aluOp_e'(stepTable[idx][fAluOp][3:0]);
	endtask

	task automatic checkStep(input int idx);
		logic [31:0] mask;
		mask = stepTable[idx][fMask];
		if (mask[0])
			checkValue("busOut", busOut, stepTable[idx][fBus]);
		if (mask[1])
			checkValue("pc", pc, stepTable[idx][fBus + 1]);
		if (mask[2])
			checkValue("mar", mar, stepTable[idx][fBus + 2]);
		if (mask[3])
			checkValue("ir", ir, stepTable[idx][fBus + 3]);
		if (mask[4])
			checkValue("zHi", zHi, stepTable[idx][fBus + 4]);
		if (mask[5])
			checkValue("zLo", zLo, stepTable[idx][fBus + 5]);
		if (mask[6])
			checkValue("hi", hi, stepTable[idx][fBus + 6]);
		if (mask[7])
			checkValue("lo", lo, stepTable[idx][fBus + 7]);
		if (mask[8])
			checkValue("outPort", outPort, stepTable[idx][fBus + 8]);
	endtask

	initial begin
		rstN = 1'b0;
		enable = '0;
		busSelect = '0;
		mDataIn = '0;
		mdRead = 1'b0;
		inPort = '0;
		aluOp = opAdd;
		loadSteps(fileOk);
		if (!fileOk) begin
			$display("test data file %s could not be opened or holds no steps", dataFile);
			$display("Simulation finished: FAIL");
		end else begin
			cycleLimit = numSteps + resetCycles + 20;
			repeat (resetCycles) @(posedge clk);
			rstN <= 1'b1;
			for (int i = 0; i < numSteps; i++) begin
				@(posedge clk);
				applyStep(i);
				#(clkPeriod - 2);  // just before the next edge
				checkStep(i);
			end
			errorCount += UUT.uProps.assertFails;
			$display("%0d errors in %0d checks over %0d steps", errorCount, checkCount, numSteps);
			if (errorCount == 0)
				$display("Simulation finished: PASS");
			else
				$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog, armed once the step count is known
	initial begin
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout reached after %0d cycles before all steps were run", cycleCount);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* tb/datapath_testdata.txt */
# enable busSelect mDataIn mdRead inPort aluOp mask busOut pc mar ir zHi zLo hi lo outPort
# all hex, outputs as seen while the step is applied, mask bit 0 is busOut up to bit 8 outPort
# reset state and idle bus
0 0 0 0 0 0 1ff 0 0 0 0 0 0 0 0 0
0 20 0 0 ffffffff 0 1ff 0 0 0 0 0 0 0 0 0
# memory data through the MDR into r2 r3 r1
1000000 0 12345678 1 0 0 1ff 0 0 0 0 0 0 0 0 0
4 200000 0 0 0 0 1ff 12345678 0 0 0 0 0 0 0 0
1000000 4 9abcdef0 1 0 0 1ff 12345678 0 0 0 0 0 0 0 0
8 200000 0 0 0 0 1ff 9abcdef0 0 0 0 0 0 0 0 0
1000000 8 7 1 0 0 1ff 9abcdef0 0 0 0 0 0 0 0 0
2 200000 0 0 0 0 1ff 7 0 0 0 0 0 0 0 0
0 2 0 0 0 0 1ff 7 0 0 0 0 0 0 0 0
1000000 8 55555555 0 0 0 1ff 9abcdef0 0 0 0 0 0 0 0 0
0 200000 0 0 0 0 1ff 9abcdef0 0 0 0 0 0 0 0 0
# fetch, incPc wins over the pc load
100000 2 0 0 0 0 1ff 7 0 0 0 0 0 0 0 0
0 100000 0 0 0 0 1ff 7 7 0 0 0 0 0 0 0
b40000 100000 0 0 0 0 1ff 7 7 0 0 0 0 0 0 0
1000000 0 a5a50f0f 1 0 0 1ff 0 8 7 0 0 7 0 0 0
400000 200000 0 0 0 0 1ff a5a50f0f 8 7 0 0 7 0 0 0
0 0 0 0 0 0 1ff 0 8 7 a5a50f0f 0 7 0 0 0
# ALU with Y from r2
80000 4 0 0 0 0 1ff 12345678 8 7 a5a50f0f 0 7 0 0 0
40000 2 0 0 0 0 1ff 7 8 7 a5a50f0f 0 7 0 0 0
0 80000 0 0 0 0 1ff 1234567f 8 7 a5a50f0f 0 1234567f 0 0 0
40000 2 0 0 0 1 1ff 7 8 7 a5a50f0f 0 1234567f 0 0 0
0 80000 0 0 0 0 1ff 12345671 8 7 a5a50f0f 0 12345671 0 0 0
40000 8 0 0 0 2 1ff 9abcdef0 8 7 a5a50f0f 0 12345671 0 0 0
0 80000 0 0 0 0 1ff 12345670 8 7 a5a50f0f 0 12345670 0 0 0
40000 8 0 0 0 3 1ff 9abcdef0 8 7 a5a50f0f 0 12345670 0 0 0
0 80000 0 0 0 0 1ff 9abcdef8 8 7 a5a50f0f 0 9abcdef8 0 0 0
40000 2 0 0 0 4 1ff 7 8 7 a5a50f0f 0 9abcdef8 0 0 0
0 80000 0 0 0 0 1ff 1a2b3c00 8 7 a5a50f0f 0 1a2b3c00 0 0 0
40000 2 0 0 0 5 1ff 7 8 7 a5a50f0f 0 1a2b3c00 0 0 0
0 80000 0 0 0 0 1ff 2468ac 8 7 a5a50f0f 0 2468ac 0 0 0
40000 2 0 0 0 6 1ff 7 8 7 a5a50f0f 0 2468ac 0 0 0
0 80000 0 0 0 0 1ff 1a2b3c09 8 7 a5a50f0f 0 1a2b3c09 0 0 0
40000 2 0 0 0 7 1ff 7 8 7 a5a50f0f 0 1a2b3c09 0 0 0
0 80000 0 0 0 0 1ff f02468ac 8 7 a5a50f0f 0 f02468ac 0 0 0
40000 2 0 0 0 8 1ff 7 8 7 a5a50f0f 0 f02468ac 0 0 0
0 80000 0 0 0 0 1ff fffffff9 8 7 a5a50f0f 0 fffffff9 0 0 0
40000 8 0 0 0 9 1ff 9abcdef0 8 7 a5a50f0f 0 fffffff9 0 0 0
0 80000 0 0 0 0 1ff 6543210f 8 7 a5a50f0f 0 6543210f 0 0 0
# signed multiply and divide with Y from r3
80000 8 0 0 0 0 1ff 9abcdef0 8 7 a5a50f0f 0 6543210f 0 0 0
40000 2 0 0 0 a 1ff 7 8 7 a5a50f0f 0 6543210f 0 0 0
0 80000 0 0 0 0 1ff 3b2a1890 8 7 a5a50f0f fffffffd 3b2a1890 0 0 0
0 40000 0 0 0 0 1ff fffffffd 8 7 a5a50f0f fffffffd 3b2a1890 0 0 0
40000 2 0 0 0 b 1ff 7 8 7 a5a50f0f fffffffd 3b2a1890 0 0 0
0 80000 0 0 0 0 1ff f188b223 8 7 a5a50f0f fffffffb f188b223 0 0 0
0 40000 0 0 0 0 1ff fffffffb 8 7 a5a50f0f fffffffb f188b223 0 0 0
40000 1 0 0 0 b 1ff 0 8 7 a5a50f0f fffffffb f188b223 0 0 0
0 80000 0 0 0 0 1ff ffffffff 8 7 a5a50f0f 9abcdef0 ffffffff 0 0 0
# HI LO and the ports
10000 40000 0 0 0 0 1ff 9abcdef0 8 7 a5a50f0f 9abcdef0 ffffffff 0 0 0
20000 80000 0 0 0 0 1ff ffffffff 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 0 0
0 10000 0 0 0 0 1ff 9abcdef0 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 0
0 20000 0 0 0 0 1ff ffffffff 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 0
10 400000 0 0 13572468 0 1ff 13572468 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 0
2000000 10 0 0 0 0 1ff 13572468 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 0
0 0 0 0 0 0 1ff 0 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 13572468
200000 100000 0 0 0 0 1ff 8 8 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 13572468
0 0 0 0 0 0 1ff 0 9 7 a5a50f0f 9abcdef0 ffffffff 9abcdef0 ffffffff 13572468

/* datapath.f */
src/cpuPkg.sv
src/busMux.sv
src/regFile.sv
src/memInterface.sv
src/alu.sv
src/datapath.sv
tb/datapath_props.sv
tb/datapathTb.sv

/* Bender.yml */
package:
  name: datapath

dependencies: {}

sources:
  # design, package first
  - src/cpuPkg.sv
  - src/busMux.sv
  - src/regFile.sv
  - src/memInterface.sv
  - src/alu.sv
  - src/datapath.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/datapath_props.sv
      - tb/datapathTb.sv
